//--- rv_slice_pkg.sv
// Shared widths, opcodes and stage records for the RV32I decode/execute slice
// XLEN is fixed at 32; only base integer opcodes are known to the decoder
`default_nettype none

package rv_slice_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;      // Data, PC and immediate values
  typedef logic [4:0]      reg_addr_t;
  typedef logic [6:0]      opcode_t;

  // RV32I major opcodes
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_auipc  = 7'b0010111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_reg    = 7'b0110011;

  typedef enum logic [3:0] {
    alu_add,    // Zero encoding, also the bubble value
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b  // lui
  } alu_op_e;

  typedef struct packed {
    word_t      pc;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    reg_addr_t  rs1_addr;    // Zero when the instruction does not read rs1
    reg_addr_t  rs2_addr;    // Zero when the instruction does not read rs2
    reg_addr_t  rd_addr;
    alu_op_e    alu_op;
    logic [2:0] funct3;
    logic       alu_src;     // Operand B is the immediate
    logic       pc_src;      // Operand A is the PC
    logic       branch;
    logic       jump;
    logic       jalr;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic       valid;
  } id_ex_t;

  typedef struct packed {
    word_t      result;      // ALU result, link address or memory address
    word_t      store_data;
    reg_addr_t  rd_addr;
    logic [2:0] funct3;      // Access size for the memory stage
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic       valid;
  } ex_mem_t;

endpackage

`default_nettype wire

//--- decode_unit.sv
// Combinational RV32I decoder; unknown opcodes come out with valid low, no trap
// Register addresses an instruction does not read are forced to x0
`timescale 1ns/1ps
`default_nettype none

module decode_unit import rv_slice_pkg::*; (
  input  word_t  instr,
  input  word_t  pc,
  input  word_t  rs1_rdata,
  input  word_t  rs2_rdata,
  input  logic   instr_valid,
  output id_ex_t id_out
);

  opcode_t    opcode;
  logic [2:0] funct3;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  id_ex_t     dec;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // alt is funct7 bit 5, picks sub and sra
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_sel = alt ? alu_sub : alu_add;
      3'b001:  alu_sel = alu_sll;
      3'b010:  alu_sel = alu_slt;
      3'b011:  alu_sel = alu_sltu;
      3'b100:  alu_sel = alu_xor;
      3'b101:  alu_sel = alt ? alu_sra : alu_srl;
      3'b110:  alu_sel = alu_or;
      default: alu_sel = alu_and;
    endcase
  endfunction

  always_comb begin
    dec          = '0;
    dec.pc       = pc;
    dec.rs1_data = rs1_rdata;
    dec.rs2_data = rs2_rdata;
    dec.rs1_addr = instr[19:15];
    dec.rs2_addr = instr[24:20];
    dec.rd_addr  = instr[11:7];
    dec.funct3   = funct3;
    dec.valid    = instr_valid;
    case (opcode)
      op_lui, op_auipc: begin
        dec.imm       = imm_u;
        dec.alu_src   = 1'b1;
        dec.pc_src    = (opcode == op_auipc);
        dec.alu_op    = (opcode == op_lui) ? alu_pass_b : alu_add;
        dec.reg_write = 1'b1;
        dec.rs1_addr  = '0;
        dec.rs2_addr  = '0;
      end
      op_jal: begin
        dec.imm       = imm_j;
        dec.alu_src   = 1'b1;
        dec.pc_src    = 1'b1;
        dec.jump      = 1'b1;
        dec.reg_write = 1'b1;
        dec.rs1_addr  = '0;
        dec.rs2_addr  = '0;
      end
      op_jalr, op_load, op_imm: begin
        dec.imm       = imm_i;
        dec.alu_src   = 1'b1;
        dec.jump      = (opcode == op_jalr);
        dec.jalr      = (opcode == op_jalr);
        dec.mem_read  = (opcode == op_load);
        dec.reg_write = 1'b1;
        dec.rs2_addr  = '0;
        if (opcode == op_imm) dec.alu_op = alu_sel(funct3, (funct3 == 3'b101) && instr[30]);
      end
      op_branch: begin
        dec.imm     = imm_b;
        dec.branch  = 1'b1;
        dec.alu_op  = alu_sub;
        dec.rd_addr = '0;
      end
      op_store: begin
        dec.imm       = imm_s;
        dec.alu_src   = 1'b1;      // Address is rs1 + imm
        dec.mem_write = 1'b1;
        dec.rd_addr   = '0;
      end
      op_reg: begin
        dec.alu_op    = alu_sel(funct3, instr[30]);
        dec.reg_write = 1'b1;
      end
      default: dec.valid  = 1'b0;  // Unknown opcode
    endcase
  end

  // Not valid: controls and addresses cleared, operand data kept
  always_comb begin
    id_out          = '0;
    id_out.pc       = pc;
    id_out.rs1_data = rs1_rdata;
    id_out.rs2_data = rs2_rdata;
    if (dec.valid) id_out = dec;
  end

endmodule

`default_nettype wire

//--- hazard_unit.sv
// Load-use detection against the ID/EX entry, plus flush for stall or redirect
// Relies on the ID/EX register never holding mem_read on an invalid entry
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import rv_slice_pkg::*; (
  input  id_ex_t id_in,           // Decoded instruction in ID
  input  id_ex_t ex_in,           // Current ID/EX entry
  input  logic   redirect_valid,
  output logic   stall,
  output logic   flush
);

  logic rs1_hit;
  logic rs2_hit;
  logic load_in_ex;

  assign rs1_hit = (id_in.rs1_addr == ex_in.rd_addr);
  assign rs2_hit = (id_in.rs2_addr == ex_in.rd_addr);

  // x0 never carries a dependence
  assign load_in_ex = ex_in.mem_read && (ex_in.rd_addr != '0);

  assign stall = id_in.valid && load_in_ex && (rs1_hit || rs2_hit);

  // Bubble into ID/EX on a stall, squash the younger one on a redirect
  assign flush = stall || redirect_valid;

  // mem_read in ID/EX must only ever come from a valid decoded load
  stall_valid_a: assert final (!stall || ex_in.valid)
    else $error("load-use stall raised for an invalid ID/EX entry");

endmodule

`default_nettype wire

//--- idex_register.sv
// ID/EX pipeline register; hold beats flush, flush inserts a bubble
// A bubble keeps PC, operand data and immediate and clears everything else
`timescale 1ns/1ps
`default_nettype none

module idex_register import rv_slice_pkg::*; (
  input  logic   clk,
  input  logic   reset_n,
  input  logic   hold,      // Freeze, from the memory side
  input  logic   flush,     // Load-use bubble or redirect squash
  input  id_ex_t id_in,
  output id_ex_t ex_out
);

  id_ex_t bubble;

  always_comb begin
    bubble          = '0;   // Controls, valid and addresses cleared
    bubble.pc       = id_in.pc;
    bubble.rs1_data = id_in.rs1_data;
    bubble.rs2_data = id_in.rs2_data;
    bubble.imm      = id_in.imm;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ex_out <= '0;
    end else if (flush && !hold) begin
      ex_out <= bubble;
    end else if (!hold) begin
      ex_out <= id_in;
    end
    // Hold keeps the entry in place
  end

endmodule

`default_nettype wire

//--- execute_stage.sv
// Execute stage with EX/MEM forwarding, branch resolution and the EX/MEM register
// Only the EX/MEM result is forwarded; older results must come in on rs1/rs2 data
// Redirect is combinational from the ID/EX entry and suppressed while hold is high
`timescale 1ns/1ps
`default_nettype none

module execute_stage import rv_slice_pkg::*; (
  input  logic    clk,
  input  logic    reset_n,
  input  logic    hold,
  input  id_ex_t  ex_in,
  output ex_mem_t ex_mem,
  output logic    redirect_valid,
  output word_t   redirect_pc
);

  logic    fwd_ok, fwd_rs1, fwd_rs2;
  word_t   rs1_val, rs2_val;
  word_t   op_a, op_b, alu_result;
  word_t   jump_base, target;
  logic    cond, taken;
  ex_mem_t ex_next;

  // Loads never match here thanks to the load-use stall
  assign fwd_ok  = ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read &&
                   (ex_mem.rd_addr != '0);
  assign fwd_rs1 = fwd_ok && (ex_mem.rd_addr == ex_in.rs1_addr);
  assign fwd_rs2 = fwd_ok && (ex_mem.rd_addr == ex_in.rs2_addr);

  assign rs1_val = fwd_rs1 ? ex_mem.result : ex_in.rs1_data;
  assign rs2_val = fwd_rs2 ? ex_mem.result : ex_in.rs2_data;

  assign op_a = ex_in.pc_src ? ex_in.pc : rs1_val;   // auipc, jal
  assign op_b = ex_in.alu_src ? ex_in.imm : rs2_val;

  always_comb begin
    case (ex_in.alu_op)
      alu_add:    alu_result = op_a + op_b;
      alu_sub:    alu_result = op_a - op_b;
      alu_sll:    alu_result = op_a << op_b[4:0];
      alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:    alu_result = op_a ^ op_b;
      alu_srl:    alu_result = op_a >> op_b[4:0];
      alu_sra:    alu_result = $signed(op_a) >>> op_b[4:0];
      alu_or:     alu_result = op_a | op_b;
      alu_and:    alu_result = op_a & op_b;
      alu_pass_b: alu_result = op_b;
      default:    alu_result = op_a + op_b;
    endcase
  end

  // Branch compare on the forwarded operands
  always_comb begin
    case (ex_in.funct3)
      3'b000:  cond = (rs1_val == rs2_val);                    // beq
      3'b001:  cond = (rs1_val != rs2_val);                    // bne
      3'b100:  cond = ($signed(rs1_val) < $signed(rs2_val));   // blt
      3'b101:  cond = ($signed(rs1_val) >= $signed(rs2_val));  // bge
      3'b110:  cond = (rs1_val < rs2_val);                     // bltu
      3'b111:  cond = (rs1_val >= rs2_val);                    // bgeu
      default: cond = 1'b0;
    endcase
  end

  assign jump_base   = ex_in.jalr ? rs1_val : ex_in.pc;
  assign target      = jump_base + ex_in.imm;
  assign redirect_pc = {target[xlen-1:1], 1'b0};  // Bit 0 cleared for jalr

  assign taken          = ex_in.valid && (ex_in.jump || (ex_in.branch && cond));
  assign redirect_valid = taken && !hold;

  always_comb begin
    ex_next = '0;
    if (ex_in.valid) begin
      // Jumps write back the link address
      ex_next.result     = ex_in.jump ? ex_in.pc + word_t'(4) : alu_result;
      ex_next.store_data = rs2_val;
      ex_next.rd_addr    = ex_in.rd_addr;
      ex_next.funct3     = ex_in.funct3;
      ex_next.mem_read   = ex_in.mem_read;
      ex_next.mem_write  = ex_in.mem_write;
      ex_next.reg_write  = ex_in.reg_write;
      ex_next.valid      = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ex_mem <= '0;
    end else if (!hold) begin
      ex_mem <= ex_next;
    end
  end

  // The flush on redirect must squash the next ID/EX entry
  redirect_pulse_a: assert property (@(posedge clk) disable iff (!reset_n)
    redirect_valid |=> !redirect_valid)
    else $error("redirect held for more than one cycle");

endmodule

`default_nettype wire

//--- rv_id_ex_core.sv
// Decode/execute slice top: decode, hazard unit, ID/EX register and execute
// While stall is high the caller must keep the same instruction applied
// An instruction accepted at edge N shows up on ex_mem after edge N+2
`timescale 1ns/1ps
`default_nettype none

module rv_id_ex_core import rv_slice_pkg::*; (
  input  logic    clk,
  input  logic    reset_n,
  input  word_t   instr,
  input  word_t   pc,
  input  word_t   rs1_rdata,
  input  word_t   rs2_rdata,
  input  logic    instr_valid,
  input  logic    hold,          // Freezes both pipeline registers
  output ex_mem_t ex_mem,
  output logic    stall,         // Load-use stall towards fetch
  output logic    redirect_valid,
  output word_t   redirect_pc
);

  id_ex_t id_dec;     // Decoded instruction in ID
  id_ex_t ex_entry;   // ID/EX register contents
  logic   idex_flush;

  decode_unit u_decode (
    .instr       (instr),
    .pc          (pc),
    .rs1_rdata   (rs1_rdata),
    .rs2_rdata   (rs2_rdata),
    .instr_valid (instr_valid),
    .id_out      (id_dec)
  );

  hazard_unit u_hazard (
    .id_in          (id_dec),
    .ex_in          (ex_entry),
    .redirect_valid (redirect_valid),
    .stall          (stall),
    .flush          (idex_flush)
  );

  idex_register u_idex (
    .clk     (clk),
    .reset_n (reset_n),
    .hold    (hold),
    .flush   (idex_flush),
    .id_in   (id_dec),
    .ex_out  (ex_entry)
  );

  execute_stage u_execute (
    .clk            (clk),
    .reset_n        (reset_n),
    .hold           (hold),
    .ex_in          (ex_entry),
    .ex_mem         (ex_mem),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

endmodule

`default_nettype wire

//--- tb_rv_id_ex_core.sv
// Self-checking testbench for the decode/execute slice
// Reads rv_id_ex_patterns.txt from the project root, one cycle per line, 14 hex words
// Outputs are sampled 1 ns before the next rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_rv_id_ex_core import rv_slice_pkg::*; ();

  localparam int clk_period = 100;  // ns
  localparam int num_lines  = 26;
  localparam int num_fields = 14;

  logic    clk;
  logic    reset_n;
  word_t   instr;
  word_t   pc;
  word_t   rs1_rdata;
  word_t   rs2_rdata;
  logic    instr_valid;
  logic    hold;
  ex_mem_t ex_mem;
  logic    stall;
  logic    redirect_valid;
  word_t   redirect_pc;

  logic [31:0] pattern [0:num_lines*num_fields-1];
  int          check_count;
  int          error_count;
  int          group_checks;
  int          group_errors;

  rv_id_ex_core u_rv_id_ex_core (
    .clk            (clk),
    .reset_n        (reset_n),
    .instr          (instr),
    .pc             (pc),
    .rs1_rdata      (rs1_rdata),
    .rs2_rdata      (rs2_rdata),
    .instr_valid    (instr_valid),
    .hold           (hold),
    .ex_mem         (ex_mem),
    .stall          (stall),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic string group_name(input logic [31:0] id);
    case (id)
      1:       group_name = "reset";
      2:       group_name = "arith";
      3:       group_name = "forward";
      4:       group_name = "load_use";
      5:       group_name = "branch";
      6:       group_name = "hold";
      7:       group_name = "illegal";
      default: group_name = "unknown";
    endcase
  endfunction

  task automatic check_value(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    group_checks++;
    if (actual !== expected) begin
      error_count++;
      group_errors++;
      $display("FAILED %s %s expected %h actual %h", test, field, expected, actual);
    end
  endtask

  task automatic apply_inputs(input int line);
    int base;
    base = line * num_fields;
    instr       <= pattern[base + 1];
    pc          <= pattern[base + 2];
    rs1_rdata   <= pattern[base + 3];
    rs2_rdata   <= pattern[base + 4];
    instr_valid <= pattern[base + 5][0];
    hold        <= pattern[base + 6][0];
  endtask

  // Record fields only matter for a valid record; rd and result only when written back
  task automatic check_outputs(input int line);
    int    base;
    string tag;
    base = line * num_fields;
    tag  = $sformatf("%s line %0d", group_name(pattern[base]), line);
    check_value(tag, "ex_mem.valid", pattern[base + 7], ex_mem.valid);
    if (pattern[base + 7][0]) begin
      check_value(tag, "ex_mem.reg_write", pattern[base + 10], ex_mem.reg_write);
      if (pattern[base + 10][0]) begin
        check_value(tag, "ex_mem.rd_addr", pattern[base + 8], ex_mem.rd_addr);
        check_value(tag, "ex_mem.result", pattern[base + 9], ex_mem.result);
      end
    end
    check_value(tag, "stall", pattern[base + 11], stall);
    check_value(tag, "redirect_valid", pattern[base + 12], redirect_valid);
    if (pattern[base + 12][0]) check_value(tag, "redirect_pc", pattern[base + 13], redirect_pc);
  endtask

  task automatic report_group(input logic [31:0] id);
    $display("Test %s done: %0d checks, %0d mismatches", group_name(id), group_checks,
             group_errors);
    group_checks = 0;
    group_errors = 0;
  endtask

  initial begin
    int          line;
    logic [31:0] cur_group;
    reset_n      = 1'b0;
    instr        = '0;
    pc           = '0;
    rs1_rdata    = '0;
    rs2_rdata    = '0;
    instr_valid  = 1'b0;
    hold         = 1'b0;
    check_count  = 0;
    error_count  = 0;
    group_checks = 0;
    group_errors = 0;
    $readmemh("rv_id_ex_patterns.txt", pattern);
    if ($isunknown(pattern[num_lines*num_fields-1])) begin
      $display("Pattern file rv_id_ex_patterns.txt is missing or shorter than expected");
      error_count++;
    end else begin
      cur_group = pattern[0];
      repeat (4) @(posedge clk);
      #(clk_period - 1);
      check_value("reset", "ex_mem.valid", 32'd0, ex_mem.valid);  // Still in reset
      check_value("reset", "stall", 32'd0, stall);
      check_value("reset", "redirect_valid", 32'd0, redirect_valid);
      @(posedge clk);
      reset_n <= 1'b1;
      for (line = 0; line < num_lines; line++) begin
        @(posedge clk);
        apply_inputs(line);
        #(clk_period - 1);
        if (pattern[line * num_fields] != cur_group) begin
          report_group(cur_group);
          cur_group = pattern[line * num_fields];
        end
        check_outputs(line);
      end
      report_group(cur_group);
    end
    $display("Total: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog sized from the pattern length plus margin for reset
  initial begin
    #((num_lines + 20) * clk_period);
    $display("Run timed out before all pattern lines were checked");
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_id_ex_patterns.txt
// grp instr pc rs1_rdata rs2_rdata instr_valid hold | expected in the same cycle:
// ex_mem.valid ex_mem.rd_addr ex_mem.result ex_mem.reg_write stall redirect_valid redirect_pc
1 00000000 00000000 00000000 00000000 0 0 0 00 00000000 0 0 0 00000000
2 00500093 00000100 00000000 00000000 1 0 0 00 00000000 0 0 0 00000000
2 123451b7 00000104 00000000 00000000 1 0 0 00 00000000 0 0 0 00000000
2 40628233 00000108 00000010 00000030 1 0 1 01 00000005 1 0 0 00000000
2 009423b3 0000010c fffffff0 00000003 1 0 1 03 12345000 1 0 0 00000000
2 40c5d533 00000110 80000000 00000004 1 0 1 04 ffffffe0 1 0 0 00000000
2 00002697 00000114 00000000 00000000 1 0 1 07 00000001 1 0 0 00000000
3 07f00713 00000118 00000000 00000000 1 0 1 0a f8000000 1 0 0 00000000
3 00e707b3 0000011c dead0000 dead0000 1 0 1 0d 00002114 1 0 0 00000000
3 40e78833 00000120 00000bad 0000007f 1 0 1 0e 0000007f 1 0 0 00000000
4 008a2883 00000124 00001000 00000000 1 0 1 0f 000000fe 1 0 0 00000000
4 00188913 00000128 00000000 00000000 1 0 1 10 0000007f 1 1 0 00000000
4 00188913 00000128 00000041 00000000 1 0 1 11 00001008 1 0 0 00000000
5 016a8863 0000012c 00000005 00000005 1 0 0 00 00000000 0 0 0 00000000
5 05500b93 00000130 00000000 00000000 1 0 1 12 00000042 1 0 1 0000013c
5 020000ef 0000013c 00000000 00000000 1 0 1 00 00000000 0 0 0 00000000
5 05500b93 00000140 00000000 00000000 1 0 0 00 00000000 0 0 1 0000015c
5 016a8863 0000015c 00000001 00000002 1 0 1 01 00000140 1 0 0 00000000
6 09900c93 00000160 00000000 00000000 1 0 0 00 00000000 0 0 0 00000000
6 016a9463 00000164 00000001 00000002 1 0 1 00 00000000 0 0 0 00000000
6 00300c13 00000168 00000000 00000000 1 1 1 19 00000099 1 0 0 00000000
6 00300c13 00000168 00000000 00000000 1 1 1 19 00000099 1 0 0 00000000
6 00300c13 00000168 00000000 00000000 1 0 1 19 00000099 1 0 1 0000016c
7 ffffffff 0000016c 00000000 00000000 1 0 1 00 00000000 0 0 0 00000000
7 00000000 00000170 00000000 00000000 0 0 0 00 00000000 0 0 0 00000000
7 00000000 00000170 00000000 00000000 0 0 0 00 00000000 0 0 0 00000000

//--- sources.f
rv_slice_pkg.sv
decode_unit.sv
hazard_unit.sv
idex_register.sv
execute_stage.sv
rv_id_ex_core.sv
tb_rv_id_ex_core.sv
